//--- hw/ifu_pkg.sv
package ifu_pkg;

    // data and instruction word width
    parameter int xlen = 32;

    // fetch address width
    parameter int addr_w = 32;

    // first fetch address out of reset
    parameter logic [addr_w-1:0] reset_pc = 32'h0000_0000;

    // axi-lite response code, only okay is ever returned here
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

    // fetch master states
    typedef enum logic [1:0] {
        // waiting for a pc to fetch
        idle = 2'b00,
        // arvalid up, waiting for arready
        addr = 2'b01,
        // rready up, waiting for rvalid
        data = 2'b10
    } fetch_state_e;

endpackage

//--- hw/pc_gen.sv
module pc_gen
    import ifu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              pc_advance,
    input  logic              redirect_valid,
    input  logic [addr_w-1:0] redirect_pc,
    output logic [addr_w-1:0] pc
);

    logic [addr_w-1:0] pc_q;
    logic [addr_w-1:0] pc_next;

    // redirect wins over the sequential step
    always_comb begin
        pc_next = pc_q;
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (pc_advance) begin
            pc_next = pc_q + addr_w'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= reset_pc;
        end else begin
            // fetches are always word aligned
            pc_q <= {pc_next[addr_w-1:2], 2'b00};
        end
    end

    assign pc = pc_q;

endmodule

//--- hw/inst_fetch.sv
module inst_fetch
    import ifu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_enable,
    input  logic              redirect_valid,
    input  logic [addr_w-1:0] pc,
    input  logic              space,
    output logic              pc_advance,
    output logic              arvalid,
    output logic [addr_w-1:0] araddr,
    input  logic              arready,
    input  logic              rvalid,
    input  logic [xlen-1:0]   rdata,
    input  axi_resp_e         rresp,
    output logic              rready,
    output logic              push,
    output logic [xlen-1:0]   push_inst,
    output logic [addr_w-1:0] push_pc,
    output logic              claim
);

    // addi x0, x0, 0 stands in for a word that came back with an error
    localparam logic [xlen-1:0] nop_inst = xlen'(32'h0000_0013);

    fetch_state_e      state;
    logic [addr_w-1:0] req_pc;
    logic              stale;
    logic              issue;
    logic              ar_hs;
    logic              r_hs;

    // no fetch while the pc is being replaced this cycle
    assign issue = (state == idle) && fetch_enable && space && !redirect_valid;
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    assign arvalid    = (state == addr);
    assign rready     = (state == data);
    assign araddr     = req_pc;
    assign pc_advance = ar_hs;
    assign claim      = issue;

    // a read issued before a redirect never reaches the queue
    assign push      = r_hs && !stale && !redirect_valid;
    assign push_inst = (rresp == okay) ? rdata : nop_inst;
    assign push_pc   = req_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stale <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (issue) begin
                        state <= addr;
                    end
                end
                addr: begin
                    if (ar_hs) begin
                        // accepted in the redirect cycle, so already stale
                        state <= data;
                        stale <= redirect_valid;
                    end else if (redirect_valid) begin
                        state <= idle;
                    end
                end
                data: begin
                    if (r_hs) begin
                        state <= idle;
                        stale <= 1'b0;
                    end else if (redirect_valid) begin
                        stale <= 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // tag for the response
    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc <= pc;
        end
    end

endmodule

//--- hw/inst_sram.sv
module inst_sram
    import ifu_pkg::*;
#(
    parameter int mem_words    = 256,
    parameter int read_latency = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              arvalid,
    input  logic [addr_w-1:0] araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [xlen-1:0]   rdata,
    output axi_resp_e         rresp,
    input  logic              rready,
    input  logic              awvalid,
    input  logic [addr_w-1:0] awaddr,
    output logic              awready,
    input  logic              wvalid,
    input  logic [xlen-1:0]   wdata,
    input  logic [xlen/8-1:0] wstrb,
    output logic              wready,
    output logic              bvalid,
    output axi_resp_e         bresp,
    input  logic              bready
);

    localparam int idx_w = $clog2(mem_words);
    localparam int lat_w = $clog2(read_latency + 1);

    logic [xlen-1:0]  mem [mem_words];
    logic             rd_busy;
    logic [lat_w-1:0] rd_cnt;
    logic [idx_w-1:0] rd_idx;
    logic             rd_fire;
    logic             ar_hs;
    logic             wr_hs;
    logic             wr_rdy;

    assign ar_hs   = arvalid && arready;
    assign arready = !rd_busy;
    assign rresp   = okay;

    // data is taken from the array in the cycle before rvalid rises
    assign rd_fire = (ar_hs && read_latency == 1) ||
                     (rd_busy && !rvalid && rd_cnt == lat_w'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
            rvalid  <= 1'b0;
        end else if (ar_hs) begin
            rd_busy <= 1'b1;
            rd_cnt  <= lat_w'(read_latency - 1);
            rvalid  <= rd_fire;
        end else if (rvalid && rready) begin
            rd_busy <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rd_busy && !rvalid) begin
            rd_cnt <= rd_cnt - lat_w'(1);
            rvalid <= rd_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_idx <= araddr[idx_w+1:2];
        end
        if (rd_fire) begin
            rdata <= mem[ar_hs ? araddr[idx_w+1:2] : rd_idx];
        end
    end

    // load port, address and data accepted together
    assign wr_hs   = awvalid && wvalid && wr_rdy;
    assign awready = wr_rdy;
    assign wready  = wr_rdy;
    assign bresp   = okay;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            wr_rdy <= 1'b0;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
            wr_rdy <= 1'b0;
        end else if (bvalid && bready) begin
            bvalid <= 1'b0;
            wr_rdy <= 1'b1;
        end else if (!bvalid) begin
            wr_rdy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            for (int b = 0; b < xlen / 8; b++) begin
                if (wstrb[b]) begin
                    mem[awaddr[idx_w+1:2]][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- hw/fetch_queue.sv
module fetch_queue
    import ifu_pkg::*;
#(
    parameter int queue_depth = 4,
    parameter int max_credits = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              claim,
    input  logic              push,
    input  logic [xlen-1:0]   push_inst,
    input  logic [addr_w-1:0] push_pc,
    output logic              space,
    output logic              inst_valid,
    output logic [xlen-1:0]   inst,
    output logic [addr_w-1:0] inst_pc,
    input  logic              credit_return
);

    localparam int ptr_w  = $clog2(queue_depth);
    localparam int cnt_w  = $clog2(queue_depth + 1);
    localparam int cred_w = $clog2(max_credits + 1);

    logic [xlen-1:0]   inst_mem [queue_depth];
    logic [addr_w-1:0] pc_mem   [queue_depth];
    logic [ptr_w-1:0]  rd_ptr;
    logic [ptr_w-1:0]  wr_ptr;
    logic [cnt_w-1:0]  count;
    logic [cnt_w-1:0]  reserved;
    logic [cred_w-1:0] credits;
    logic              send;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(queue_depth - 1)) ? '0 : p + ptr_w'(1);
    endfunction

    // entries plus slots promised to an in-flight read
    assign space = ({1'b0, count} + {1'b0, reserved}) < (cnt_w + 1)'(queue_depth);

    // the redirect cycle sends nothing, old entries are gone next edge
    assign send       = (count != '0) && (credits != '0) && !flush;
    assign inst_valid = send;
    assign inst       = inst_mem[rd_ptr];
    assign inst_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            reserved <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (send) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count + cnt_w'(push) - cnt_w'(send);
            reserved <= reserved + cnt_w'(claim) - cnt_w'(push);
        end
    end

    // credits survive a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
        end else begin
            credits <= credits + cred_w'(credit_return) - cred_w'(send);
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            inst_mem[wr_ptr] <= push_inst;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

endmodule

//--- hw/ifu_top.sv
module ifu_top
    import ifu_pkg::*;
#(
    parameter int mem_words    = 256,
    parameter int read_latency = 2,
    parameter int queue_depth  = 4,
    parameter int max_credits  = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_enable,
    input  logic              redirect_valid,
    input  logic [addr_w-1:0] redirect_pc,
    input  logic              load_valid,
    input  logic [addr_w-1:0] load_addr,
    input  logic [xlen-1:0]   load_data,
    output logic              load_ready,
    output logic              inst_valid,
    output logic [xlen-1:0]   inst,
    output logic [addr_w-1:0] inst_pc,
    input  logic              credit_return
);

    logic [addr_w-1:0] pc;
    logic              pc_advance;
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic              arready;
    logic              rvalid;
    logic [xlen-1:0]   rdata;
    axi_resp_e         rresp;
    logic              rready;
    logic              awready;
    logic              wready;
    logic              push;
    logic [xlen-1:0]   push_inst;
    logic [addr_w-1:0] push_pc;
    logic              claim;
    logic              space;

    // boot loader writes full words
    assign load_ready = awready && wready;

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .pc_advance     (pc_advance),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (pc)
    );

    inst_fetch u_inst_fetch (
        .clk            (clk),
        .rst            (rst),
        .fetch_enable   (fetch_enable),
        .redirect_valid (redirect_valid),
        .pc             (pc),
        .space          (space),
        .pc_advance     (pc_advance),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .arready        (arready),
        .rvalid         (rvalid),
        .rdata          (rdata),
        .rresp          (rresp),
        .rready         (rready),
        .push           (push),
        .push_inst      (push_inst),
        .push_pc        (push_pc),
        .claim          (claim)
    );

    // write response is always okay, so it is accepted and dropped
    inst_sram #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) u_inst_sram (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready),
        .awvalid (load_valid),
        .awaddr  (load_addr),
        .awready (awready),
        .wvalid  (load_valid),
        .wdata   (load_data),
        .wstrb   ({(xlen / 8){1'b1}}),
        .wready  (wready),
        .bvalid  (),
        .bresp   (),
        .bready  (1'b1)
    );

    fetch_queue #(
        .queue_depth (queue_depth),
        .max_credits (max_credits)
    ) u_fetch_queue (
        .clk           (clk),
        .rst           (rst),
        .flush         (redirect_valid),
        .claim         (claim),
        .push          (push),
        .push_inst     (push_inst),
        .push_pc       (push_pc),
        .space         (space),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .credit_return (credit_return)
    );

endmodule

//--- verif/ifu_assertions.sv
module ifu_assertions
    import ifu_pkg::*;
#(
    parameter int mem_words = 256
) (
    input logic              clk,
    input logic              rst,
    input logic              load_valid,
    input logic [addr_w-1:0] load_addr,
    input logic [xlen-1:0]   load_data,
    input logic              load_ready,
    input logic              redirect_valid,
    input logic [addr_w-1:0] redirect_pc,
    input logic              inst_valid,
    input logic [xlen-1:0]   inst,
    input logic [addr_w-1:0] inst_pc,
    input logic              credit_return
);

    localparam int idx_w = $clog2(mem_words);

    logic [xlen-1:0]   shadow [mem_words];
    logic [addr_w-1:0] exp_pc;
    logic              rst_q;
    int                credit_model;
    int                fails = 0;

    // shadow copy of whatever the boot loader wrote
    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (load_valid && load_ready) begin
            shadow[load_addr[idx_w+1:2]] <= load_data;
        end
    end

    // credits held by the queue and the pc the next sent instruction must carry
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_model <= 0;
            exp_pc       <= reset_pc;
        end else begin
            credit_model <= credit_model + int'(credit_return) - int'(inst_valid);
            if (redirect_valid) begin
                exp_pc <= {redirect_pc[addr_w-1:2], 2'b00};
            end else if (inst_valid) begin
                exp_pc <= exp_pc + addr_w'(4);
            end
        end
    end

    quiet_in_reset: assert property (@(posedge clk) rst && rst_q |-> !inst_valid && !load_ready)
        else begin
            $error("inst_valid or load_ready was high during reset");
            fails++;
        end

    credit_held: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> credit_model > 0)
        else begin
            $error("an instruction was sent with no credit held");
            fails++;
        end

    inst_matches_memory: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst == shadow[inst_pc[idx_w+1:2]])
        else begin
            $error("ERROR inst: got %h, expected %h at inst_pc %h", $sampled(inst),
                   $sampled(shadow[inst_pc[idx_w+1:2]]), $sampled(inst_pc));
            fails++;
        end

    pc_in_order: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_pc == exp_pc)
        else begin
            $error("ERROR inst_pc: got %h, expected %h", $sampled(inst_pc), $sampled(exp_pc));
            fails++;
        end

endmodule

bind ifu_top ifu_assertions #(
    .mem_words (mem_words)
) ifu_checks (
    .clk            (clk),
    .rst            (rst),
    .load_valid     (load_valid),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .load_ready     (load_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .inst_pc        (inst_pc),
    .credit_return  (credit_return)
);

//--- verif/ifu_tb.sv
module ifu_tb
    import ifu_pkg::*;
();

    localparam int mem_words      = 256;
    localparam int read_latency   = 2;
    localparam int queue_depth    = 4;
    localparam int max_credits    = 4;
    localparam int prog_words     = 64;
    localparam int redirects      = 12;
    localparam int expected_insts = 48 + redirects * 6;
    localparam int timeout_cycles =
        expected_insts * (read_latency + 6) + prog_words * 4 + 600;

    logic              clk;
    logic              rst;
    logic              fetch_enable;
    logic              redirect_valid;
    logic [addr_w-1:0] redirect_pc;
    logic              load_valid;
    logic [addr_w-1:0] load_addr;
    logic [xlen-1:0]   load_data;
    logic              load_ready;
    logic              inst_valid;
    logic [xlen-1:0]   inst;
    logic [addr_w-1:0] inst_pc;
    logic              credit_return;

    int                received = 0;
    int                held = 0;
    int                gaps [64];
    int                gap_idx = 0;
    int                gap = 0;
    bit                credits_on = 1'b0;
    logic [addr_w-1:0] last_pc;
    int                tb_fails = 0;
    int                tests_run = 0;
    int                failed_tests = 0;
    int                marked_errors = 0;

    ifu_top #(
        .mem_words    (mem_words),
        .read_latency (read_latency),
        .queue_depth  (queue_depth),
        .max_credits  (max_credits)
    ) uut (
        .clk            (clk),
        .rst            (rst),
        .fetch_enable   (fetch_enable),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .load_valid     (load_valid),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .load_ready     (load_ready),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .credit_return  (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // decode side model, one credit per free slot after a random gap
    initial begin
        bit give;
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            give = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (credits_on && held < max_credits) begin
                give = 1'b1;
                gap = gaps[gap_idx % 64];
                gap_idx++;
            end
            #2;
            credit_return = give;
            if (give) begin
                held++;
            end
        end
    end

    // mid-cycle sampling of the decode transfer
    always @(negedge clk) begin
        if (!rst && inst_valid) begin
            received++;
            held--;
            last_pc = inst_pc;
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, %0d instructions received", timeout_cycles, received);
        $display("Something failed");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic load_word(input logic [addr_w-1:0] a, input logic [xlen-1:0] d);
        int k;
        load_valid = 1'b1;
        load_addr  = a;
        load_data  = d;
        k = 0;
        while (!load_ready && k < 10) begin
            step();
            k++;
        end
        if (!load_ready) begin
            $display("load of address %h was never accepted", a);
            tb_fails++;
        end
        step();
        load_valid = 1'b0;
    endtask

    task automatic wait_for_insts(input int n);
        int target;
        target = received + n;
        while (received < target) begin
            step();
        end
    endtask

    task automatic redirect_to(input logic [addr_w-1:0] target);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        step();
        redirect_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = tb_fails + uut.ifu_checks.fails - marked_errors;
        tests_run++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errs == 0) ? "passed" : "failed", errs);
        marked_errors = tb_fails + uut.ifu_checks.fails;
    endtask

    initial begin
        int k;
        int mark;
        void'($urandom(32'h469b));
        rst            = 1'b1;
        fetch_enable   = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        load_valid     = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        for (int i = 0; i < 64; i++) begin
            gaps[i] = $urandom_range(3, 0);
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < prog_words; i++) begin
            load_word(addr_w'(i * 4), $urandom());
        end
        // queue fills but nothing may leave without a credit
        fetch_enable = 1'b1;
        repeat (20) step();
        if (received != 0) begin
            $display("an instruction was sent before any credit was returned");
            tb_fails++;
        end
        finish_test("reset, load, no output without credits");

        credits_on = 1'b1;
        wait_for_insts(32);
        finish_test("fetched words match memory");

        wait_for_insts(8);
        if (last_pc != reset_pc + addr_w'(4 * (received - 1))) begin
            $display("ERROR inst_pc: last sent %h, expected %h", last_pc,
                     reset_pc + addr_w'(4 * (received - 1)));
            tb_fails++;
        end
        finish_test("sequential pc from reset");

        credits_on = 1'b0;
        step();
        k = 0;
        while (held != 0 && k < 100) begin
            step();
            k++;
        end
        if (held != 0) begin
            $display("granted credits were never used up");
            tb_fails++;
        end
        mark = received;
        repeat (40) step();
        if (received != mark) begin
            $display("output kept going while no credits were held");
            tb_fails++;
        end
        credits_on = 1'b1;
        wait_for_insts(8);
        finish_test("credit withholding and resume");

        for (int i = 0; i < redirects; i++) begin
            k = 0;
            if (i % 2 == 0) begin
                // land on a read that is still outstanding
                while (!uut.rready && k < 20) begin
                    step();
                    k++;
                end
            end else begin
                repeat ($urandom_range(6, 0)) step();
            end
            redirect_to(addr_w'($urandom_range(31, 0) * 4));
            wait_for_insts($urandom_range(6, 1));
        end
        finish_test("redirects");

        $display("%0d tests, %0d failed, %0d testbench errors, %0d assertion errors",
                 tests_run, failed_tests, tb_fails, uut.ifu_checks.fails);
        if (failed_tests == 0 && tb_fails + uut.ifu_checks.fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/ifu_pkg.sv
hw/pc_gen.sv
hw/inst_fetch.sv
hw/inst_sram.sv
hw/fetch_queue.sv
hw/ifu_top.sv
verif/ifu_assertions.sv
verif/ifu_tb.sv
